/* Bender.yml */
package:
  name: cos

sources:
  - cosPkg.sv
  - cosUartRx.sv
  - cosUartTx.sv
  - cosCommandParser.sv
  - cosCsrSplitter.sv
  - cosResetGen.sv
  - cosLedCsr.sv
  - cosLedPwm.sv
  - cosGpio.sv
  - cosTop.sv
  - target: test
    files:
      - tbCos.sv

/* compile.f */
cosPkg.sv
cosUartRx.sv
cosUartTx.sv
cosCommandParser.sv
cosCsrSplitter.sv
cosResetGen.sv
cosLedCsr.sv
cosLedPwm.sv
cosGpio.sv
cosTop.sv
tbCos.sv

/* cosCommandParser.sv */
// Command parser FSM from UART bytes to register requests and response bytes
`timescale 1ns/1ns
`default_nettype none

module cosCommandParser (
  input  logic                          clock,
  input  logic                          rst,
  input  logic                          rxValid,
  input  logic [cosPkg::DataWidth-1:0]  rxByte,
  output logic                          txValid,
  output logic [cosPkg::DataWidth-1:0]  txByte,
  input  logic                          txReady,
  output logic                          reqValid,
  output logic                          reqWrite,
  output logic [cosPkg::AddrWidth-1:0]  reqAddr,
  output logic [cosPkg::DataWidth-1:0]  reqData,
  input  logic                          reqReady,
  input  logic                          respValid,
  input  logic [cosPkg::DataWidth-1:0]  respData,
  input  logic                          respError,
  output logic                          resetRequest
);

  typedef enum logic [2:0] {
    PsIdle,
    PsAddress,
    PsData,
    PsRequest,
    PsWaitResp,
    PsSendStatus,
    PsSendData
  } parserState;

  parserState                    state;
  logic                          isWrite;
  logic [cosPkg::DataWidth-1:0]  statusByte;
  logic [cosPkg::DataWidth-1:0]  readByte;

  assign reqValid = (state == PsRequest);
  assign reqWrite = isWrite;
  assign txValid = (state == PsSendStatus) || (state == PsSendData);
  assign txByte = (state == PsSendData) ? readByte : statusByte;

  always_ff @(posedge clock) begin
    if (rst) begin
      state <= PsIdle;
      resetRequest <= 1'b0;
    end else begin
      resetRequest <= 1'b0;
      case (state)
        PsIdle: begin
          // Anything that is not an opcode is dropped
          if (rxValid) begin
            case (cosPkg::cmdOpcode'(rxByte))
              cosPkg::CmdWrite: begin
                isWrite <= 1'b1;
                state <= PsAddress;
              end
              cosPkg::CmdRead: begin
                isWrite <= 1'b0;
                state <= PsAddress;
              end
              cosPkg::CmdReset: resetRequest <= 1'b1;
              default: state <= PsIdle;
            endcase
          end
        end
        PsAddress: begin
          if (rxValid) begin
            reqAddr <= rxByte;
            state <= isWrite ? PsData : PsRequest;
          end
        end
        PsData: begin
          if (rxValid) begin
            reqData <= rxByte;
            state <= PsRequest;
          end
        end
        PsRequest: begin
          if (reqReady) state <= PsWaitResp;
        end
        PsWaitResp: begin
          if (respValid) begin
            statusByte <= respError ? cosPkg::StatusNak : cosPkg::StatusAck;
            readByte <= respError ? '0 : respData;
            state <= PsSendStatus;
          end
        end
        // Held here while the transmitter is busy
        PsSendStatus: begin
          if (txReady) state <= isWrite ? PsIdle : PsSendData;
        end
        PsSendData: begin
          if (txReady) state <= PsIdle;
        end
        default: state <= PsIdle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* cosCsrSplitter.sv */
// Register bus splitter that routes requests by block number
`timescale 1ns/1ns
`default_nettype none

module cosCsrSplitter (
  input  logic                              clock,
  input  logic                              rst,
  // Parser side
  input  logic                              reqValid,
  input  logic                              reqWrite,
  input  logic [cosPkg::AddrWidth-1:0]      reqAddr,
  input  logic [cosPkg::DataWidth-1:0]      reqData,
  output logic                              reqReady,
  output logic                              respValid,
  output logic [cosPkg::DataWidth-1:0]      respData,
  output logic                              respError,
  // LED block
  output logic                              ledSelect,
  output logic                              ledWrite,
  output logic [cosPkg::RegIndexWidth-1:0]  ledRegIndex,
  output logic [cosPkg::DataWidth-1:0]      ledWriteData,
  input  logic                              ledRespValid,
  input  logic [cosPkg::DataWidth-1:0]      ledReadData,
  input  logic                              ledError,
  // GPIO block
  output logic                              gpioSelect,
  output logic                              gpioWrite,
  output logic [cosPkg::RegIndexWidth-1:0]  gpioRegIndex,
  output logic [cosPkg::DataWidth-1:0]      gpioWriteData,
  input  logic                              gpioRespValid,
  input  logic [cosPkg::DataWidth-1:0]      gpioReadData,
  input  logic                              gpioError
);

  logic                              busy;
  logic                              unknownPulse;
  logic [cosPkg::BlockIdWidth-1:0]   blockId;
  logic [cosPkg::BlockIdWidth-1:0]   reqBlock;
  logic                              writeQ;
  logic [cosPkg::RegIndexWidth-1:0]  regIndexQ;
  logic [cosPkg::DataWidth-1:0]      writeDataQ;

  assign reqReady = !busy;
  assign reqBlock = reqAddr[cosPkg::AddrWidth-1 -: cosPkg::BlockIdWidth];

  // Both blocks see the same registered request, only the select differs
  assign ledWrite = writeQ;
  assign ledRegIndex = regIndexQ;
  assign ledWriteData = writeDataQ;
  assign gpioWrite = writeQ;
  assign gpioRegIndex = regIndexQ;
  assign gpioWriteData = writeDataQ;

  always_ff @(posedge clock) begin
    if (rst) begin
      busy <= 1'b0;
      blockId <= cosPkg::BlockLed;
      ledSelect <= 1'b0;
      gpioSelect <= 1'b0;
      unknownPulse <= 1'b0;
    end else begin
      ledSelect <= 1'b0;
      gpioSelect <= 1'b0;
      unknownPulse <= 1'b0;
      if (reqValid && reqReady) begin
        busy <= 1'b1;
        blockId <= reqBlock;
        ledSelect <= (reqBlock == cosPkg::BlockLed);
        gpioSelect <= (reqBlock == cosPkg::BlockGpio);
        unknownPulse <= (reqBlock != cosPkg::BlockLed) && (reqBlock != cosPkg::BlockGpio);
      end else if (respValid) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reqValid && reqReady) begin
      writeQ <= reqWrite;
      regIndexQ <= reqAddr[cosPkg::RegIndexWidth-1:0];
      writeDataQ <= reqData;
    end
  end

  // Response mux, unknown blocks answer one cycle early with an error
  always_comb begin
    case (blockId)
      cosPkg::BlockLed: begin
        respValid = ledRespValid;
        respData = ledReadData;
        respError = ledError;
      end
      cosPkg::BlockGpio: begin
        respValid = gpioRespValid;
        respData = gpioReadData;
        respError = gpioError;
      end
      default: begin
        respValid = unknownPulse;
        respData = '0;
        respError = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

/* cosGpio.sv */
// GPIO output, output enable and synchronized input registers
`timescale 1ns/1ns
`default_nettype none

module cosGpio (
  input  logic                              clock,
  input  logic                              rst,
  input  logic                              select,
  input  logic                              write,
  input  logic [cosPkg::RegIndexWidth-1:0]  regIndex,
  input  logic [cosPkg::DataWidth-1:0]      writeData,
  output logic                              respValid,
  output logic [cosPkg::DataWidth-1:0]      readData,
  output logic                              error,
  output logic [cosPkg::GpioCount-1:0]      gpioOut,
  output logic [cosPkg::GpioCount-1:0]      gpioTristate,
  input  logic [cosPkg::GpioCount-1:0]      gpioIn
);

  logic [cosPkg::GpioCount-1:0]  outValue;
  logic [cosPkg::GpioCount-1:0]  enable;
  logic [cosPkg::GpioCount-1:0]  inMeta;
  logic [cosPkg::GpioCount-1:0]  inSync;

  assign gpioOut = outValue;
  assign gpioTristate = ~enable;

  always_ff @(posedge clock) begin
    if (rst) begin
      outValue <= '0;
      enable <= '0;
      respValid <= 1'b0;
    end else begin
      respValid <= select;
      // Input register is read only, writes to it are dropped
      if (select && write) begin
        if (regIndex == cosPkg::GpioRegOut) outValue <= writeData;
        if (regIndex == cosPkg::GpioRegEnable) enable <= writeData;
      end
    end
  end

  always_ff @(posedge clock) begin
    inMeta <= gpioIn;
    inSync <= inMeta;
    if (select) begin
      error <= (regIndex > cosPkg::GpioRegIn);
      case (regIndex)
        cosPkg::GpioRegOut: readData <= outValue;
        cosPkg::GpioRegEnable: readData <= enable;
        cosPkg::GpioRegIn: readData <= inSync;
        default: readData <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* cosLedCsr.sv */
// LED brightness registers with read-back and index range check
`timescale 1ns/1ns
`default_nettype none

module cosLedCsr (
  input  logic                                                clock,
  input  logic                                                rst,
  input  logic                                                select,
  input  logic                                                write,
  input  logic [cosPkg::RegIndexWidth-1:0]                    regIndex,
  input  logic [cosPkg::DataWidth-1:0]                        writeData,
  output logic                                                respValid,
  output logic [cosPkg::DataWidth-1:0]                        readData,
  output logic                                                error,
  output logic [cosPkg::LedCount-1:0][cosPkg::DataWidth-1:0]  brightness
);

  logic  inRange;

  assign inRange = (regIndex < cosPkg::LedCount);

  always_ff @(posedge clock) begin
    if (rst) begin
      brightness <= '0;
      respValid <= 1'b0;
    end else begin
      respValid <= select;
      if (select && write && inRange) begin
        brightness[regIndex] <= writeData;
      end
    end
  end

  // Read data is the value before any write in the same cycle
  always_ff @(posedge clock) begin
    if (select) begin
      error <= !inRange;
      readData <= inRange ? brightness[regIndex] : '0;
    end
  end

endmodule

`default_nettype wire

/* cosLedPwm.sv */
// Free-running PWM counter with one comparator per LED
`timescale 1ns/1ns
`default_nettype none

module cosLedPwm (
  input  logic                                                clock,
  input  logic                                                rst,
  input  logic [cosPkg::LedCount-1:0][cosPkg::DataWidth-1:0]  brightness,
  output logic [cosPkg::LedCount-1:0]                         ledOut
);

  logic [cosPkg::DataWidth-1:0]  counter;

  // High for exactly brightness cycles out of every 256
  always_ff @(posedge clock) begin
    if (rst) begin
      counter <= '0;
      ledOut <= '0;
    end else begin
      counter <= counter + 1'b1;
      for (int i = 0; i < cosPkg::LedCount; i++) begin
        ledOut[i] <= (counter < brightness[i]);
      end
    end
  end

endmodule

`default_nettype wire

/* cosPkg.sv */
// Register bus widths, block numbers, status codes, UART timing and command opcodes
`default_nettype none

package cosPkg;

  // ****************************************
  // Register bus
  // ****************************************
  localparam int DataWidth = 8;
  localparam int RegIndexWidth = 4;
  localparam int BlockIdWidth = 4;
  // Block number in the upper nibble, register index in the lower
  localparam int AddrWidth = BlockIdWidth + RegIndexWidth;

  localparam logic [BlockIdWidth-1:0] BlockLed = 4'd0;
  localparam logic [BlockIdWidth-1:0] BlockGpio = 4'd1;

  // One register word per block
  localparam int LedCount = 4;
  localparam int GpioCount = 8;

  // GPIO register map
  localparam logic [RegIndexWidth-1:0] GpioRegOut = 4'd0;
  localparam logic [RegIndexWidth-1:0] GpioRegEnable = 4'd1;
  localparam logic [RegIndexWidth-1:0] GpioRegIn = 4'd2;

  // ****************************************
  // UART timing and reset
  // ****************************************
  localparam int ClocksPerBit = 8;
  localparam int ClockCountWidth = $clog2(ClocksPerBit);
  // Ten bit times lets the line go idle
  localparam int ResetCycles = 10 * ClocksPerBit;
  localparam int ResetCountWidth = $clog2(ResetCycles + 1);

  // ****************************************
  // Command protocol
  // ****************************************
  localparam logic [DataWidth-1:0] StatusAck = 8'h06;
  localparam logic [DataWidth-1:0] StatusNak = 8'h15;

  typedef enum logic [DataWidth-1:0] {
    CmdWrite = 8'h57,
    CmdRead  = 8'h52,
    CmdReset = 8'h5A
  } cmdOpcode;

endpackage

`default_nettype wire

/* cosResetGen.sv */
// Reset stretcher for the external reset and the reset command
`timescale 1ns/1ns
`default_nettype none

module cosResetGen (
  input  logic  clock,
  input  logic  rst,
  input  logic  resetRequest,
  output logic  resetCore
);

  logic [cosPkg::ResetCountWidth-1:0]  count;

  // Reload while any source is active, then count down to release
  always_ff @(posedge clock) begin
    if (rst || resetRequest) begin
      count <= cosPkg::ResetCountWidth'(cosPkg::ResetCycles);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign resetCore = rst || resetRequest || (count != '0);

endmodule

`default_nettype wire

/* cosTop.sv */
// Chip control core top with UART, parser, splitter, LED, GPIO and reset generator
`timescale 1ns/1ns
`default_nettype none

module cosTop (
  input  logic                          clock,
  input  logic                          rst,
  input  logic                          uartRx,
  output logic                          uartTx,
  output logic [cosPkg::LedCount-1:0]   ledOut,
  output logic [cosPkg::GpioCount-1:0]  gpioOut,
  output logic [cosPkg::GpioCount-1:0]  gpioTristate,
  input  logic [cosPkg::GpioCount-1:0]  gpioIn
);

  logic                                                resetCore;
  logic                                                resetRequest;
  logic                                                rxValid;
  logic [cosPkg::DataWidth-1:0]                        rxByte;
  logic                                                txValid;
  logic                                                txReady;
  logic [cosPkg::DataWidth-1:0]                        txByte;
  logic                                                reqValid;
  logic                                                reqWrite;
  logic [cosPkg::AddrWidth-1:0]                        reqAddr;
  logic [cosPkg::DataWidth-1:0]                        reqData;
  logic                                                reqReady;
  logic                                                respValid;
  logic [cosPkg::DataWidth-1:0]                        respData;
  logic                                                respError;
  logic                                                ledSelect;
  logic                                                ledWrite;
  logic [cosPkg::RegIndexWidth-1:0]                    ledRegIndex;
  logic [cosPkg::DataWidth-1:0]                        ledWriteData;
  logic                                                ledRespValid;
  logic [cosPkg::DataWidth-1:0]                        ledReadData;
  logic                                                ledError;
  logic [cosPkg::LedCount-1:0][cosPkg::DataWidth-1:0]  brightness;
  logic                                                gpioSelect;
  logic                                                gpioWrite;
  logic [cosPkg::RegIndexWidth-1:0]                    gpioRegIndex;
  logic [cosPkg::DataWidth-1:0]                        gpioWriteData;
  logic                                                gpioRespValid;
  logic [cosPkg::DataWidth-1:0]                        gpioReadData;
  logic                                                gpioError;

  // ****************************************
  // Reset and UART control
  // ****************************************
  cosResetGen uResetGen (.clock(clock), .rst(rst), .resetRequest(resetRequest),
                         .resetCore(resetCore));

  cosUartRx uUartRx (.clock(clock), .rst(resetCore), .uartRx(uartRx),
                     .rxValid(rxValid), .rxByte(rxByte));

  cosUartTx uUartTx (.clock(clock), .rst(resetCore), .txValid(txValid), .txByte(txByte),
                     .txReady(txReady), .uartTx(uartTx));

  cosCommandParser uParser (.clock(clock), .rst(resetCore),
                            .rxValid(rxValid), .rxByte(rxByte),
                            .txValid(txValid), .txByte(txByte), .txReady(txReady),
                            .reqValid(reqValid), .reqWrite(reqWrite), .reqAddr(reqAddr),
                            .reqData(reqData), .reqReady(reqReady),
                            .respValid(respValid), .respData(respData),
                            .respError(respError), .resetRequest(resetRequest));

  // ****************************************
  // Register splitter and blocks
  // ****************************************
  cosCsrSplitter uSplitter (.clock(clock), .rst(resetCore),
                            .reqValid(reqValid), .reqWrite(reqWrite), .reqAddr(reqAddr),
                            .reqData(reqData), .reqReady(reqReady),
                            .respValid(respValid), .respData(respData), .respError(respError),
                            .ledSelect(ledSelect), .ledWrite(ledWrite),
                            .ledRegIndex(ledRegIndex), .ledWriteData(ledWriteData),
                            .ledRespValid(ledRespValid), .ledReadData(ledReadData),
                            .ledError(ledError),
                            .gpioSelect(gpioSelect), .gpioWrite(gpioWrite),
                            .gpioRegIndex(gpioRegIndex), .gpioWriteData(gpioWriteData),
                            .gpioRespValid(gpioRespValid), .gpioReadData(gpioReadData),
                            .gpioError(gpioError));

  cosLedCsr uLedCsr (.clock(clock), .rst(resetCore), .select(ledSelect), .write(ledWrite),
                     .regIndex(ledRegIndex), .writeData(ledWriteData),
                     .respValid(ledRespValid), .readData(ledReadData), .error(ledError),
                     .brightness(brightness));

  cosLedPwm uLedPwm (.clock(clock), .rst(resetCore), .brightness(brightness), .ledOut(ledOut));

  cosGpio uGpio (.clock(clock), .rst(resetCore), .select(gpioSelect), .write(gpioWrite),
                 .regIndex(gpioRegIndex), .writeData(gpioWriteData),
                 .respValid(gpioRespValid), .readData(gpioReadData), .error(gpioError),
                 .gpioOut(gpioOut), .gpioTristate(gpioTristate), .gpioIn(gpioIn));

endmodule

`default_nettype wire

/* cosUartRx.sv */
// UART receiver with line synchronizer and mid-bit sampling
`timescale 1ns/1ns
`default_nettype none

module cosUartRx (
  input  logic                          clock,
  input  logic                          rst,
  input  logic                          uartRx,
  output logic                          rxValid,
  output logic [cosPkg::DataWidth-1:0]  rxByte
);

  typedef enum logic {RxIdle, RxBusy} rxState;

  rxState                                state;
  logic                                  rxMeta;
  logic                                  rxLine;
  logic [cosPkg::ClockCountWidth-1:0]    clockCount;
  logic [3:0]                            bitCount;
  logic [cosPkg::DataWidth-1:0]          shiftReg;

  assign rxByte = shiftReg;

  always_ff @(posedge clock) begin
    if (rst) begin
      rxMeta <= 1'b1;
      rxLine <= 1'b1;
      state <= RxIdle;
      rxValid <= 1'b0;
      clockCount <= '0;
      bitCount <= '0;
    end else begin
      rxMeta <= uartRx;
      rxLine <= rxMeta;
      rxValid <= 1'b0;
      case (state)
        RxIdle: begin
          // Falling edge, wait half a bit to the start bit middle
          if (!rxLine) begin
            state <= RxBusy;
            clockCount <= cosPkg::ClockCountWidth'(cosPkg::ClocksPerBit / 2 - 1);
            bitCount <= '0;
          end
        end
        RxBusy: begin
          if (clockCount != '0) begin
            clockCount <= clockCount - 1'b1;
          end else begin
            clockCount <= cosPkg::ClockCountWidth'(cosPkg::ClocksPerBit - 1);
            bitCount <= bitCount + 1'b1;
            if (bitCount == 4'd0) begin
              // Glitch, not a real start bit
              if (rxLine) state <= RxIdle;
            end else if (bitCount == 4'd9) begin
              // Stop bit must be high or the frame is dropped
              state <= RxIdle;
              rxValid <= rxLine;
            end else begin
              shiftReg <= {rxLine, shiftReg[cosPkg::DataWidth-1:1]};
            end
          end
        end
        default: state <= RxIdle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* cosUartTx.sv */
// UART transmitter with valid/ready byte input
`timescale 1ns/1ns
`default_nettype none

module cosUartTx (
  input  logic                          clock,
  input  logic                          rst,
  input  logic                          txValid,
  input  logic [cosPkg::DataWidth-1:0]  txByte,
  output logic                          txReady,
  output logic                          uartTx
);

  typedef enum logic {TxIdle, TxBusy} txState;

  txState                                state;
  logic [cosPkg::ClockCountWidth-1:0]    clockCount;
  logic [3:0]                            bitCount;
  logic [cosPkg::DataWidth-1:0]          shiftReg;

  assign txReady = (state == TxIdle);

  always_ff @(posedge clock) begin
    if (rst) begin
      state <= TxIdle;
      uartTx <= 1'b1;
      clockCount <= '0;
      bitCount <= '0;
    end else begin
      case (state)
        TxIdle: begin
          if (txValid) begin
            state <= TxBusy;
            uartTx <= 1'b0;
            shiftReg <= txByte;
            clockCount <= cosPkg::ClockCountWidth'(cosPkg::ClocksPerBit - 1);
            bitCount <= '0;
          end
        end
        TxBusy: begin
          if (clockCount != '0) begin
            clockCount <= clockCount - 1'b1;
          end else begin
            clockCount <= cosPkg::ClockCountWidth'(cosPkg::ClocksPerBit - 1);
            bitCount <= bitCount + 1'b1;
            if (bitCount == 4'd9) begin
              state <= TxIdle;
            end else if (bitCount == 4'd8) begin
              uartTx <= 1'b1;
            end else begin
              // Data goes out LSB first
              uartTx <= shiftReg[0];
              shiftReg <= shiftReg >> 1;
            end
          end
        end
        default: state <= TxIdle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* tbCos.sv */
// Testbench for cosTop with UART host model, register reference model and response checks
`timescale 1ns/1ns
`default_nettype none

module tbCos;

  localparam logic [31:0] Seed = 32'h384cfcbf;
  // Response wait of four frames after the last command frame
  localparam int ResponseLimit = 40 * cosPkg::ClocksPerBit;
  // About 45 commands of up to 5 frames at 80 cycles, 8 PWM windows and margin
  localparam int CycleLimit = 60000;

  logic                          clock;
  logic                          rst;
  logic                          uartRx;
  logic                          uartTx;
  logic [cosPkg::LedCount-1:0]   ledOut;
  logic [cosPkg::GpioCount-1:0]  gpioOut;
  logic [cosPkg::GpioCount-1:0]  gpioTristate;
  logic [cosPkg::GpioCount-1:0]  gpioIn;

  // Register model of both blocks
  logic [cosPkg::DataWidth-1:0]  ledModel[cosPkg::LedCount];
  logic [cosPkg::DataWidth-1:0]  gpioOutModel;
  logic [cosPkg::DataWidth-1:0]  gpioEnModel;

  // Response bytes still owed by the DUT
  logic [cosPkg::DataWidth-1:0]  expectQ[$];
  string                         labelQ[$];
  int                            valueErrors = 0;
  int                            otherErrors = 0;
  int                            cycleCount;

  cosTop cosTop_inst (.clock(clock), .rst(rst), .uartRx(uartRx), .uartTx(uartTx),
                      .ledOut(ledOut), .gpioOut(gpioOut), .gpioTristate(gpioTristate),
                      .gpioIn(gpioIn));

  always #2 clock = ~clock;

  // ****************************************
  // Reference model and checks
  // ****************************************
  function automatic logic [15:0] referenceResponse(input logic isWrite,
                                                    input logic [7:0] addr);
    logic [3:0]  block;
    logic [3:0]  index;
    logic        ok;
    logic [7:0]  data;
    block = addr[7:4];
    index = addr[3:0];
    ok = 1'b0;
    data = 8'h00;
    if (block == cosPkg::BlockLed && index < cosPkg::LedCount) begin
      ok = 1'b1;
      data = ledModel[index];
    end else if (block == cosPkg::BlockGpio && index <= 4'd2) begin
      ok = 1'b1;
      if (index == 4'd0) data = gpioOutModel;
      else if (index == 4'd1) data = gpioEnModel;
      else data = gpioIn;
    end
    // Nak and writes carry no data
    return {ok ? cosPkg::StatusAck : cosPkg::StatusNak, (ok && !isWrite) ? data : 8'h00};
  endfunction

  task automatic updateModel(input logic [7:0] addr, input logic [7:0] data);
    if (addr[7:4] == cosPkg::BlockLed && addr[3:0] < cosPkg::LedCount) begin
      ledModel[addr[3:0]] = data;
    end else if (addr[7:4] == cosPkg::BlockGpio && addr[3:0] == 4'd0) begin
      gpioOutModel = data;
    end else if (addr[7:4] == cosPkg::BlockGpio && addr[3:0] == 4'd1) begin
      gpioEnModel = data;
    end
  endtask

  task automatic resetModel();
    int i;
    for (i = 0; i < cosPkg::LedCount; i++) ledModel[i] = 8'h00;
    gpioOutModel = 8'h00;
    gpioEnModel = 8'h00;
  endtask

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      valueErrors++;
    end
  endtask

  task automatic checkResetState(input string when);
    checkValue(uartTx, 1, {when, ": uartTx"});
    checkValue(ledOut, 0, {when, ": ledOut"});
    checkValue(gpioOut, 0, {when, ": gpioOut"});
    checkValue(gpioTristate, {cosPkg::GpioCount{1'b1}}, {when, ": gpioTristate"});
  endtask

  // ****************************************
  // UART host model
  // ****************************************
  task automatic sendByte(input logic [7:0] value);
    logic [9:0]  frame;
    int          i;
    frame = {1'b1, value, 1'b0};
    for (i = 0; i < 10; i++) begin
      uartRx = frame[i];
      repeat (cosPkg::ClocksPerBit) @(negedge clock);
    end
  endtask

  task automatic awaitResponse();
    int waited;
    waited = 0;
    while (expectQ.size() != 0 && waited < ResponseLimit) begin
      @(negedge clock);
      waited++;
    end
    if (expectQ.size() != 0) begin
      $display("response frame never arrived by %0t ns, %0d byte(s) missing",
               $time, expectQ.size());
      otherErrors++;
      expectQ.delete();
      labelQ.delete();
    end
    repeat (2 * cosPkg::ClocksPerBit) @(negedge clock);
  endtask

  task automatic writeReg(input logic [7:0] addr, input logic [7:0] data);
    logic [15:0] resp;
    resp = referenceResponse(1'b1, addr);
    expectQ.push_back(resp[15:8]);
    labelQ.push_back($sformatf("status of write to 0x%02h", addr));
    if (resp[15:8] == cosPkg::StatusAck) updateModel(addr, data);
    sendByte(cosPkg::CmdWrite);
    sendByte(addr);
    sendByte(data);
    awaitResponse();
  endtask

  task automatic readReg(input logic [7:0] addr);
    logic [15:0] resp;
    resp = referenceResponse(1'b0, addr);
    expectQ.push_back(resp[15:8]);
    labelQ.push_back($sformatf("status of read from 0x%02h", addr));
    expectQ.push_back(resp[7:0]);
    labelQ.push_back($sformatf("data of read from 0x%02h", addr));
    sendByte(cosPkg::CmdRead);
    sendByte(addr);
    awaitResponse();
  endtask

  // Count high cycles of every LED over one full PWM period
  task automatic measurePwm();
    int highCount[cosPkg::LedCount];
    int cycle;
    int led;
    for (led = 0; led < cosPkg::LedCount; led++) highCount[led] = 0;
    for (cycle = 0; cycle < 256; cycle++) begin
      @(negedge clock);
      for (led = 0; led < cosPkg::LedCount; led++) begin
        if (ledOut[led] === 1'b1) highCount[led]++;
      end
    end
    for (led = 0; led < cosPkg::LedCount; led++) begin
      checkValue(highCount[led], ledModel[led], $sformatf("ledOut[%0d] high cycles", led));
    end
  endtask

  // Decodes every frame on uartTx and compares it with the next owed byte
  initial begin : responseMonitor
    logic [7:0]  rxData;
    int          i;
    forever begin
      @(negedge clock);
      if (uartTx === 1'b0) begin
        repeat (cosPkg::ClocksPerBit / 2) @(negedge clock);
        for (i = 0; i < 8; i++) begin
          repeat (cosPkg::ClocksPerBit) @(negedge clock);
          rxData[i] = uartTx;
        end
        repeat (cosPkg::ClocksPerBit) @(negedge clock);
        if (uartTx !== 1'b1) begin
          $display("response frame ending at %0t ns has a low stop bit", $time);
          otherErrors++;
        end
        if (expectQ.size() == 0) begin
          $display("unexpected response byte 0x%02h at %0t ns", rxData, $time);
          otherErrors++;
        end else begin
          checkValue(rxData, expectQ.pop_front(), labelQ.pop_front());
        end
      end
    end
  end

  initial begin : watchdog
    cycleCount = 0;
    while (cycleCount < CycleLimit) begin
      @(posedge clock);
      cycleCount++;
    end
    $display("run stopped after %0d cycles without finishing, %0d value errors, %0d other",
             CycleLimit, valueErrors, otherErrors);
    $display("test failed");
    $finish;
  end

  // ****************************************
  // Stimulus
  // ****************************************
  initial begin : stimulus
    logic [7:0]  value;
    logic [7:0]  junk;
    int          i;
    int          round;
    void'($urandom(Seed));
    clock = 1'b0;
    rst = 1'b1;
    uartRx = 1'b1;
    gpioIn = '0;
    resetModel();
    repeat (10) @(negedge clock);
    rst = 1'b0;
    repeat (cosPkg::ResetCycles + 2) @(negedge clock);
    checkResetState("after power-on reset");

    // GPIO output value and enable
    for (round = 0; round < 3; round++) begin
      writeReg({cosPkg::BlockGpio, 4'd0}, 8'($urandom));
      writeReg({cosPkg::BlockGpio, 4'd1}, 8'($urandom));
      checkValue(gpioOut, gpioOutModel, "gpioOut pins");
      checkValue(gpioTristate, 8'(~gpioEnModel), "gpioTristate pins");
      readReg({cosPkg::BlockGpio, 4'd0});
      readReg({cosPkg::BlockGpio, 4'd1});
    end

    // GPIO input read-back and ignored writes to register 2
    for (round = 0; round < 2; round++) begin
      gpioIn = 8'($urandom);
      repeat (4) @(negedge clock);
      readReg({cosPkg::BlockGpio, 4'd2});
      writeReg({cosPkg::BlockGpio, 4'd2}, 8'($urandom));
      readReg({cosPkg::BlockGpio, 4'd2});
    end

    // LED brightness and PWM duty
    for (round = 0; round < 2; round++) begin
      for (i = 0; i < cosPkg::LedCount; i++) begin
        writeReg({cosPkg::BlockLed, 4'(i)}, 8'($urandom));
      end
      for (i = 0; i < cosPkg::LedCount; i++) readReg({cosPkg::BlockLed, 4'(i)});
      measurePwm();
    end

    // Naks for unknown block and out-of-range index
    readReg({4'($urandom_range(15, 2)), 4'($urandom_range(15, 0))});
    writeReg({4'($urandom_range(15, 2)), 4'($urandom_range(15, 0))}, 8'($urandom));
    readReg({cosPkg::BlockLed, 4'($urandom_range(15, cosPkg::LedCount))});
    writeReg({cosPkg::BlockLed, 4'($urandom_range(15, cosPkg::LedCount))}, 8'($urandom));
    readReg({cosPkg::BlockGpio, 4'($urandom_range(15, 3))});
    writeReg({cosPkg::BlockGpio, 4'($urandom_range(15, 3))}, 8'($urandom));

    // Stray byte while idle is dropped without a response
    do begin
      junk = 8'($urandom);
    end while (junk == cosPkg::CmdWrite || junk == cosPkg::CmdRead || junk == cosPkg::CmdReset);
    sendByte(junk);
    repeat (30 * cosPkg::ClocksPerBit) @(negedge clock);
    value = 8'($urandom);
    writeReg({cosPkg::BlockLed, 4'd1}, value);
    readReg({cosPkg::BlockLed, 4'd1});

    // Reset command returns everything to reset values without a response
    sendByte(cosPkg::CmdReset);
    resetModel();
    repeat (cosPkg::ResetCycles + 4 * cosPkg::ClocksPerBit) @(negedge clock);
    checkResetState("after reset command");
    for (i = 0; i < cosPkg::LedCount; i++) readReg({cosPkg::BlockLed, 4'(i)});
    readReg({cosPkg::BlockGpio, 4'd0});
    readReg({cosPkg::BlockGpio, 4'd1});
    readReg({cosPkg::BlockGpio, 4'd2});

    $display("Run finished with %0d value errors and %0d other errors",
             valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
